// ==== src.f ====
+incdir+hdl
hdl/mul_pkg.sv
hdl/mul_decode.sv
hdl/mul_stage.sv
hdl/mul_pipeline.sv
hdl/mul_result.sv
hdl/mul_unit.sv
bench/mul_clock_gen.sv
bench/mul_asserts.sv
bench/mul_tb.sv

// ==== Bender.yml ====
package:
  name: mul_unit

export_include_dirs:
  - hdl

sources:
  - hdl/mul_pkg.sv
  - hdl/mul_decode.sv
  - hdl/mul_stage.sv
  - hdl/mul_pipeline.sv
  - hdl/mul_result.sv
  - hdl/mul_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/mul_clock_gen.sv
      - bench/mul_asserts.sv
      - bench/mul_tb.sv

// ==== bench/mul_tb.sv ====
`include "mul_params.svh"

module mul_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mul_pkg::*;

	localparam int CLOCK_PERIOD    = 10;
	localparam int LATENCY         = `MUL_STAGES + 2;
	localparam int CORNERS         = 8;
	localparam int DIRECTED_ISSUES = 4 * CORNERS;
	localparam int ILLEGAL_ISSUES  = 7;
	localparam int RANDOM_ISSUES   = 2000;
	localparam int TOTAL_ISSUES    = DIRECTED_ISSUES + ILLEGAL_ISSUES + RANDOM_ISSUES;

	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	localparam logic [31:0] CORNER_A [CORNERS] = '{32'h0000_0000, 32'h0000_0001,
		32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff,
		32'h1234_5678};
	localparam logic [31:0] CORNER_B [CORNERS] = '{32'hffff_ffff, 32'h0000_0001,
		32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h7fff_ffff,
		32'h9abc_def0};

	logic        clock;
	logic        reset;
	logic        issue;
	logic [31:0] instr;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic        wb_valid;
	mul_wb_t     wb;
	logic        illegal;

	integer      seed = 32'hdb14_3961;
	mul_wb_t     expected_q [$];

	mul_clock_gen u_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	mul_unit DUT (
		.clock    (clock),
		.reset    (reset),
		.issue    (issue),
		.instr    (instr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_valid (wb_valid),
		.wb       (wb),
		.illegal  (illegal)
	);

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped after a failed check.");
	endtask

	function automatic logic [31:0] make_instr(input logic [6:0] funct7,
		input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
		return {funct7, 5'd2, 5'd1, funct3, rd, opcode};
	endfunction

	function automatic logic is_multiply(input logic [31:0] word);
		return (word[6:0] == OPCODE_OP) && (word[31:25] == FUNCT7_MULDIV) && !word[14];
	endfunction

	// Full 64-bit product of the extended operands, then the requested half.
	function automatic logic [31:0] reference_result(input logic [2:0] funct3,
		input logic [31:0] a, input logic [31:0] b);
		logic [63:0] a_ext;
		logic [63:0] b_ext;
		logic [63:0] full;
		if (funct3 == 3'd1 || funct3 == 3'd2) begin
			a_ext = {{32{a[31]}}, a};
		end else begin
			a_ext = {32'd0, a};
		end
		if (funct3 == 3'd1) begin
			b_ext = {{32{b[31]}}, b};
		end else begin
			b_ext = {32'd0, b};
		end
		full = a_ext * b_ext;
		return (funct3 == 3'd0) ? full[31:0] : full[63:32];
	endfunction

	task automatic issue_instr(input logic [31:0] word, input logic [31:0] a,
		input logic [31:0] b);
		mul_wb_t entry;
		@(posedge clock);
		#1;
		issue    = 1'b1;
		instr    = word;
		rs1_data = a;
		rs2_data = b;
		if (is_multiply(word)) begin
			entry.rd   = word[11:7];
			entry.data = reference_result(word[14:12], a, b);
			expected_q.push_back(entry);
		end
	endtask

	task automatic idle_cycle();
		@(posedge clock);
		#1 issue = 1'b0;
	endtask

	// Scoreboard, plus a watch on the bound concurrent assertions.
	always @(negedge clock) begin
		mul_wb_t expected;
		if (DUT.u_asserts.failures != 0) begin
			$display("A concurrent assertion on mul_unit failed at %0t.", $time);
			stop_with_failure();
		end
		if (!reset && wb_valid) begin
			assert (expected_q.size() != 0) else begin
				$display("wb_valid rose at %0t with no result pending.", $time);
				stop_with_failure();
			end
			expected = expected_q.pop_front();
			assert (wb.data == expected.data) else begin
				$display("error: %0t wb.data expected %h got %h",
					$time, expected.data, wb.data);
				stop_with_failure();
			end
			assert (wb.rd == expected.rd) else begin
				$display("error: %0t wb.rd expected %0d got %0d", $time, expected.rd, wb.rd);
				stop_with_failure();
			end
		end
	end

	initial begin
		#((TOTAL_ISSUES + 50) * CLOCK_PERIOD);
		$display("The test timed out before all results came back.");
		stop_with_failure();
	end

	initial begin
		logic [31:0] pick;
		logic [31:0] a;
		logic [31:0] b;
		logic [2:0]  funct3;
		issue    = 1'b0;
		instr    = '0;
		rs1_data = '0;
		rs2_data = '0;
		@(negedge reset);
		repeat (3) idle_cycle();

		for (int f = 0; f < 4; f++) begin
			for (int i = 0; i < CORNERS; i++) begin
				issue_instr(make_instr(FUNCT7_MULDIV, f[2:0], 5'(f * CORNERS + i), OPCODE_OP),
					CORNER_A[i], CORNER_B[i]);
			end
		end

		// Wrong opcode, wrong funct7, then divide funct3 values.
		issue_instr(make_instr(FUNCT7_MULDIV, 3'd0, 5'd3, 7'b0010011), 32'd5, 32'd7);
		issue_instr(make_instr(FUNCT7_MULDIV, 3'd1, 5'd4, 7'b0110111), 32'd5, 32'd7);
		issue_instr(make_instr(7'b0000000, 3'd0, 5'd5, OPCODE_OP), 32'd5, 32'd7);
		issue_instr(make_instr(7'b0100000, 3'd0, 5'd6, OPCODE_OP), 32'd5, 32'd7);
		issue_instr(make_instr(FUNCT7_MULDIV, 3'd4, 5'd7, OPCODE_OP), 32'd5, 32'd7);
		issue_instr(make_instr(FUNCT7_MULDIV, 3'd5, 5'd8, OPCODE_OP), 32'd5, 32'd7);
		issue_instr(make_instr(FUNCT7_MULDIV, 3'd7, 5'd9, OPCODE_OP), 32'd5, 32'd7);

		// Mostly multiplies, with a divide funct3 now and then.
		repeat (RANDOM_ISSUES) begin
			pick   = $random(seed);
			a      = $random(seed);
			b      = $random(seed);
			funct3 = (pick[4:2] == 3'd0) ? pick[7:5] : {1'b0, pick[6:5]};
			issue_instr(make_instr(FUNCT7_MULDIV, funct3, pick[12:8], OPCODE_OP), a, b);
		end
		idle_cycle();

		wait (expected_q.size() == 0);
		repeat (LATENCY) @(negedge clock);
		if (DUT.u_asserts.failures == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("Checks still failed at the end of the run.");
			stop_with_failure();
		end
	end

endmodule

// ==== bench/mul_asserts.sv ====
`include "mul_params.svh"

module mul_asserts (
	input logic              clock,
	input logic              reset,
	input logic              issue,
	input logic [31:0]       instr,
	input logic              wb_valid,
	input mul_pkg::mul_wb_t  wb,
	input logic              illegal
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LATENCY = `MUL_STAGES + 2;

	int unsigned failures = 0;

	logic               legal_issue;
	logic               illegal_issue;
	logic               seen_issue;
	logic               illegal_last;
	logic [LATENCY:1]   legal_hist;
	logic [4:0]         rd_hist [1:LATENCY];

	assign legal_issue = issue && (instr[6:0] == 7'b0110011) &&
		(instr[31:25] == 7'b0000001) && !instr[14];
	assign illegal_issue = issue && !legal_issue;

	always_ff @(posedge clock) begin
		if (reset) begin
			seen_issue   <= 1'b0;
			illegal_last <= 1'b0;
			legal_hist   <= '0;
		end else begin
			seen_issue   <= seen_issue || issue;
			illegal_last <= illegal_issue;
			legal_hist   <= {legal_hist[LATENCY-1:1], legal_issue};
		end
	end

	always_ff @(posedge clock) begin
		rd_hist[1] <= instr[11:7];
		for (int i = 2; i <= LATENCY; i++) begin
			rd_hist[i] <= rd_hist[i-1];
		end
	end

	quiet_after_reset: assert property (@(posedge clock) disable iff (reset)
		!seen_issue |-> (!wb_valid && !illegal))
	else begin
		$error("error: %0t wb_valid and illegal expected 0 and 0 got %b and %b",
			$time, $sampled(wb_valid), $sampled(illegal));
		failures++;
	end

	// One write-back per legal issue, a fixed latency later.
	wb_valid_timing: assert property (@(posedge clock) disable iff (reset)
		wb_valid == legal_hist[LATENCY])
	else begin
		$error("error: %0t wb_valid expected %b got %b",
			$time, $sampled(legal_hist[LATENCY]), $sampled(wb_valid));
		failures++;
	end

	wb_rd_match: assert property (@(posedge clock) disable iff (reset)
		wb_valid |-> (wb.rd == rd_hist[LATENCY]))
	else begin
		$error("error: %0t wb.rd expected %0d got %0d",
			$time, $sampled(rd_hist[LATENCY]), $sampled(wb.rd));
		failures++;
	end

	illegal_timing: assert property (@(posedge clock) disable iff (reset)
		illegal == illegal_last)
	else begin
		$error("error: %0t illegal expected %b got %b",
			$time, $sampled(illegal_last), $sampled(illegal));
		failures++;
	end

endmodule

bind mul_unit mul_asserts u_asserts (
	.clock    (clock),
	.reset    (reset),
	.issue    (issue),
	.instr    (instr),
	.wb_valid (wb_valid),
	.wb       (wb),
	.illegal  (illegal)
);

// ==== bench/mul_clock_gen.sv ====
module mul_clock_gen (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 5;
	localparam int RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// Release lines up with the stimulus, just after a rising edge.
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

// ==== hdl/mul_unit.sv ====
`include "mul_params.svh"

module mul_unit (
	input  logic             clock,
	input  logic             reset,
	input  logic             issue,
	input  logic [31:0]      instr,
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	output logic             wb_valid,
	output mul_pkg::mul_wb_t wb,
	output logic             illegal
);
	import mul_pkg::*;

	mul_req_t     req;
	logic         req_valid;
	logic         done;
	mul_product_u product;
	mul_tag_t     tag;

	mul_decode u_decode (
		.clock     (clock),
		.reset     (reset),
		.issue     (issue),
		.instr     (instr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.req       (req),
		.req_valid (req_valid),
		.illegal   (illegal)
	);

	mul_pipeline u_pipeline (
		.clock     (clock),
		.reset     (reset),
		.req_valid (req_valid),
		.req       (req),
		.done      (done),
		.product   (product),
		.tag       (tag)
	);

	mul_result u_result (
		.clock    (clock),
		.reset    (reset),
		.done     (done),
		.product  (product),
		.tag      (tag),
		.wb_valid (wb_valid),
		.wb       (wb)
	);

endmodule

// ==== hdl/mul_result.sv ====
`include "mul_params.svh"

module mul_result (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  done,
	input  mul_pkg::mul_product_u product,
	input  mul_pkg::mul_tag_t     tag,
	output logic                  wb_valid,
	output mul_pkg::mul_wb_t      wb
);
	import mul_pkg::*;

	logic [`XLEN-1:0] data_sel;
	mul_wb_t          wb_next;

	// MULH, MULHSU and MULHU return the upper word, MUL the lower.
	assign data_sel = tag.high ? product.halves.hi : product.halves.lo;

	assign wb_next.rd   = tag.rd;
	assign wb_next.data = data_sel;

	always_ff @(posedge clock) begin
		if (done) begin
			wb <= wb_next;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= done;
		end
	end

endmodule

// ==== hdl/mul_pipeline.sv ====
`include "mul_params.svh"

module mul_pipeline (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  req_valid,
	input  mul_pkg::mul_req_t     req,
	output logic                  done,
	output mul_pkg::mul_product_u product,
	output mul_pkg::mul_tag_t     tag
);
	import mul_pkg::*;

	logic [2*`XLEN-1:0] mcand_ext;
	logic [2*`XLEN-1:0] mplier_ext;

	// Element i feeds stage i; the last element is the finished product.
	mul_stage_t         chain [0:`MUL_STAGES];
	logic [`MUL_STAGES:0] start_chain;

	// Extend to full width so the low 2*XLEN bits of the sum are exact
	// for any mix of signed and unsigned operands.
	assign mcand_ext = req.sign[0] ?
		{{`XLEN{req.mcand[`XLEN-1]}}, req.mcand} :
		{{`XLEN{1'b0}}, req.mcand};

	assign mplier_ext = req.sign[1] ?
		{{`XLEN{req.mplier[`XLEN-1]}}, req.mplier} :
		{{`XLEN{1'b0}}, req.mplier};

	assign chain[0] = '{
		sum:    '0,
		mcand:  mcand_ext,
		mplier: mplier_ext,
		tag:    req.tag
	};

	assign start_chain[0] = req_valid;

	for (genvar i = 0; i < `MUL_STAGES; i++) begin : g_stage
		mul_stage u_stage (
			.clock     (clock),
			.reset     (reset),
			.start     (start_chain[i]),
			.stage_in  (chain[i]),
			.done      (start_chain[i+1]),
			.stage_out (chain[i+1])
		);
	end

	assign done         = start_chain[`MUL_STAGES];
	assign product.flat = chain[`MUL_STAGES].sum;
	assign tag          = chain[`MUL_STAGES].tag;

endmodule

// ==== hdl/mul_stage.sv ====
`include "mul_params.svh"

module mul_stage (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  mul_pkg::mul_stage_t stage_in,
	output logic                done,
	output mul_pkg::mul_stage_t stage_out
);
	import mul_pkg::*;

	// Multiplier bits consumed by each stage.
	localparam int SLICE = (2*`XLEN) / `MUL_STAGES;

	logic [2*`XLEN-1:0] part_next;
	logic [2*`XLEN-1:0] part_reg;
	logic [2*`XLEN-1:0] sum_reg;
	logic [2*`XLEN-1:0] mcand_reg;
	logic [2*`XLEN-1:0] mplier_reg;
	mul_tag_t           tag_reg;

	assign part_next = stage_in.mplier[SLICE-1:0] * stage_in.mcand;

	always_ff @(posedge clock) begin
		sum_reg    <= stage_in.sum;
		part_reg   <= part_next;
		// Next slice of the multiplier, and the multiplicand weighted to match.
		mplier_reg <= stage_in.mplier >> SLICE;
		mcand_reg  <= stage_in.mcand << SLICE;
		tag_reg    <= stage_in.tag;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	// The add sits after the register, ahead of the next stage's multiply.
	assign stage_out.sum    = sum_reg + part_reg;
	assign stage_out.mcand  = mcand_reg;
	assign stage_out.mplier = mplier_reg;
	assign stage_out.tag    = tag_reg;

endmodule

// ==== hdl/mul_decode.sv ====
`include "mul_params.svh"

module mul_decode (
	input  logic               clock,
	input  logic               reset,
	input  logic               issue,
	input  logic [31:0]        instr,
	input  logic [`XLEN-1:0]   rs1_data,
	input  logic [`XLEN-1:0]   rs2_data,
	output mul_pkg::mul_req_t  req,
	output logic               req_valid,
	output logic               illegal
);
	import mul_pkg::*;

	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	localparam logic [1:0] F3_MUL    = 2'b00;
	localparam logic [1:0] F3_MULH   = 2'b01;
	localparam logic [1:0] F3_MULHSU = 2'b10;
	localparam logic [1:0] F3_MULHU  = 2'b11;

	logic [6:0] opcode;
	logic [4:0] rd;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;
	mul_sign_t  sign;
	mul_req_t   req_next;

	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Only funct3 0 to 3 are multiplies; 4 to 7 belong to divide.
	assign legal = (opcode == OPCODE_OP) && (funct7 == FUNCT7_MULDIV) && !funct3[2];

	always_comb begin
		case (funct3[1:0])
			F3_MUL: begin
				sign = 2'b00;
			end
			F3_MULH: begin
				sign = 2'b11;
			end
			F3_MULHSU: begin
				// rs1 is the multiplicand, so bit 0.
				sign = 2'b01;
			end
			F3_MULHU: begin
				sign = 2'b00;
			end
			default: begin
				sign = 2'b00;
			end
		endcase
	end

	always_comb begin
		req_next.mcand    = rs1_data;
		req_next.mplier   = rs2_data;
		req_next.sign     = sign;
		req_next.tag.rd   = rd;
		req_next.tag.high = (funct3[1:0] != F3_MUL);
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			req <= req_next;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			req_valid <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			req_valid <= issue && legal;
			illegal   <= issue && !legal;
		end
	end

endmodule

// ==== hdl/mul_pkg.sv ====
`include "mul_params.svh"

package mul_pkg;

	// Bit 0 marks a signed multiplicand, bit 1 a signed multiplier.
	typedef logic [1:0] mul_sign_t;

	// Travels with every operation down the pipeline.
	typedef struct packed {
		logic [4:0] rd;
		logic       high;
	} mul_tag_t;

	// One decoded multiply request.
	typedef struct packed {
		logic [`XLEN-1:0] mcand;
		logic [`XLEN-1:0] mplier;
		mul_sign_t        sign;
		mul_tag_t         tag;
	} mul_req_t;

	typedef struct packed {
		logic [`XLEN-1:0] hi;
		logic [`XLEN-1:0] lo;
	} mul_halves_t;

	// Double width product, seen as one word or as two halves.
	typedef union packed {
		logic [2*`XLEN-1:0] flat;
		mul_halves_t        halves;
	} mul_product_u;

	// State handed from one multiplier stage to the next.
	typedef struct packed {
		logic [2*`XLEN-1:0] sum;
		logic [2*`XLEN-1:0] mcand;
		logic [2*`XLEN-1:0] mplier;
		mul_tag_t           tag;
	} mul_stage_t;

	// Register write-back.
	typedef struct packed {
		logic [4:0]       rd;
		logic [`XLEN-1:0] data;
	} mul_wb_t;

endpackage

// ==== hdl/mul_params.svh ====
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// Operand width of the integer datapath.
`define XLEN 32

// Multiplier stages.
// Must divide 2*XLEN; 1, 2, 4 and 8 are supported.
`define MUL_STAGES 4

`endif
